// File: Bender.yml
package:
  name: ppu_sprite_pair

export_include_dirs:
  - rtl

sources:
  - rtl/ppu_pkg.sv
  - rtl/ppu_fetch_if.sv
  - rtl/ppu_pixel_streamer.sv
  - rtl/ppu_sprite.sv
  - rtl/ppu_fetch_arbiter.sv
  - rtl/ppu_sprite_compositor.sv
  - rtl/ppu_sprite_pair.sv
  - target: simulation
    files:
      - sim/tb_ppu_checks.sv
      - sim/tb_ppu_sprite_pair.sv

// File: ppu_sprite_pair.f
+incdir+rtl
rtl/ppu_pkg.sv
rtl/ppu_fetch_if.sv
rtl/ppu_pixel_streamer.sv
rtl/ppu_sprite.sv
rtl/ppu_fetch_arbiter.sv
rtl/ppu_sprite_compositor.sv
rtl/ppu_sprite_pair.sv
sim/tb_ppu_checks.sv
sim/tb_ppu_sprite_pair.sv

// File: rtl/ppu_fetch_arbiter.sv
`timescale 1ns/1ns

module ppu_fetch_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                flush,

	ppu_fetch_if.responder      req0,
	ppu_fetch_if.responder      req1,

	output logic                wb_cyc,
	output logic                wb_stb,
	output ppu_pkg::word_addr_t wb_adr,
	input  ppu_pkg::bus_word_t  wb_dat_i,
	input  logic                wb_ack
);

logic                cyc_q;
logic                last_q;  // Last winner, also owner of the open cycle.
logic                dirty_q; // Open cycle predates a flush.
ppu_pkg::word_addr_t adr_q;
logic                any_req;
logic                win;
logic                ack_clean;

assign any_req = req0.vld || req1.vld;
assign win     = (req0.vld && req1.vld) ? !last_q : req1.vld; // Round robin.

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cyc_q   <= 1'b0;
		last_q  <= 1'b0;
		dirty_q <= 1'b0;
	end else if (!cyc_q) begin
		if (any_req && !flush) begin
			cyc_q  <= 1'b1;
			last_q <= win;
		end
	end else if (wb_ack) begin
		cyc_q   <= 1'b0;
		dirty_q <= 1'b0;
	end else if (flush) begin
		dirty_q <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (!cyc_q && any_req)
		adr_q <= win ? req1.addr : req0.addr;
end

assign wb_cyc = cyc_q;
assign wb_stb = cyc_q; // Single beat reads only.
assign wb_adr = adr_q;

// Stale data from before a line start is dropped here.
assign ack_clean = cyc_q && wb_ack && !dirty_q && !flush;
assign req0.rdy  = ack_clean && !last_q;
assign req1.rdy  = ack_clean && last_q;
assign req0.data = wb_dat_i;
assign req1.data = wb_dat_i;

// The owner of a clean cycle keeps requesting until its word comes back.
a_rdy_to_waiting: assert property (
	@(posedge clk) disable iff (!rst_n)
	ack_clean |-> (last_q ? req1.vld : req0.vld)
) else $error("wishbone data returned to a requester that stopped waiting");

endmodule

// File: rtl/ppu_fetch_if.sv
`timescale 1ns/1ns

interface ppu_fetch_if;

	logic                vld;
	logic                rdy;
	ppu_pkg::word_addr_t addr;
	ppu_pkg::bus_word_t  data; // Valid in the rdy cycle.

	modport requester (
		output vld,
		output addr,
		input  rdy,
		input  data
	);

	modport responder (
		input  vld,
		input  addr,
		output rdy,
		output data
	);

endinterface

// File: rtl/ppu_pixel_streamer.sv
`timescale 1ns/1ns

module ppu_pixel_streamer (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   flush,
	input  ppu_pkg::pix_mode_e     mode,
	input  ppu_pkg::palette_offs_t palette_offs,

	output logic                   load_req,
	input  logic                   load_ack,
	input  ppu_pkg::bus_word_t     load_data,

	output logic                   pix_vld,
	input  logic                   pix_rdy,
	output logic                   pix_alpha,
	output ppu_pkg::pix_t          pix_data
);

ppu_pkg::bus_word_t buf_q;
logic [2:0]         cnt_q;
logic               is_pal8;
logic               pix_pop;

assign is_pal8 = (mode == ppu_pkg::PIX_PAL8);
assign pix_pop = pix_vld && pix_rdy;

// ======================================================================
// Word buffer
// ======================================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cnt_q <= 3'd0;
	end else if (flush) begin
		cnt_q <= 3'd0;
	end else if (load_ack) begin
		cnt_q <= is_pal8 ? 3'd4 : 3'd2; // Pixels per word.
	end else if (pix_pop) begin
		cnt_q <= cnt_q - 3'd1;
	end
end

// Lowest pixel of the word goes out first.
always_ff @(posedge clk) begin
	if (load_ack) begin
		buf_q <= load_data;
	end else if (pix_pop) begin
		buf_q <= is_pal8 ? (buf_q >> 8) : (buf_q >> 16);
	end
end

assign load_req = (cnt_q == 3'd0);
assign pix_vld  = (cnt_q != 3'd0);

// ======================================================================
// Pixel formatting
// ======================================================================

always_comb begin
	if (is_pal8) begin
		pix_alpha = |buf_q[7:0]; // Index zero is transparent.
		pix_data  = {3'b000, palette_offs, buf_q[7:0]};
	end else begin
		pix_alpha = buf_q[15];
		pix_data  = buf_q[14:0];
	end
end

// The sprite only fetches into an empty buffer, so a load never lands
// on top of pixels that are still waiting to go out.
a_load_into_empty: assert property (
	@(posedge clk) disable iff (!rst_n)
	load_ack |-> (cnt_q == 3'd0)
) else $error("pixel streamer loaded while still holding %0d pixels", cnt_q);

endmodule

// File: rtl/ppu_pkg.sv
`include "ppu_settings.svh"

package ppu_pkg;

	// Beam position and memory side.
	typedef logic [`PPU_W_COORD-1:0] coord_t;
	typedef logic [`PPU_W_ADDR-1:0]  word_addr_t;
	typedef logic [`PPU_W_DATA-1:0]  bus_word_t;

	// Pixel side.
	typedef logic [14:0] pix_t;          // RGB555 colour.
	typedef logic [3:0]  palette_offs_t; // Goes above an 8-bit index.

	// ARGB1555 packs two pixels per word, PAL8 packs four.
	typedef enum logic {
		PIX_ARGB1555 = 1'b0,
		PIX_PAL8     = 1'b1
	} pix_mode_e;

endpackage

// File: rtl/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ======================================================================
// Scanline and sprite geometry, in pixels
// ======================================================================

`define PPU_LINE_W   64
`define PPU_SPRITE_W 16 // Sprites start on a word boundary.

// ======================================================================
// Datapath widths
// ======================================================================

`define PPU_W_COORD  10 // Beam x position.
`define PPU_W_ADDR   16 // Word address, not byte address.
`define PPU_W_DATA   32

`endif

// File: rtl/ppu_sprite.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module ppu_sprite (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   flush,
	input  logic                   en,

	input  ppu_pkg::coord_t        spr_x,
	input  ppu_pkg::word_addr_t    spr_base,
	input  logic                   spr_active,
	input  ppu_pkg::pix_mode_e     mode,
	input  ppu_pkg::palette_offs_t palette_offs,

	ppu_fetch_if.requester         fetch,

	output logic                   out_vld,
	input  logic                   out_rdy,
	output logic                   out_alpha,
	output ppu_pkg::pix_t          out_pixdata
);

localparam int W_POST       = $clog2(`PPU_SPRITE_W) + 1;
localparam int SPRITE_WORDS = `PPU_SPRITE_W / 2; // Widest case, ARGB1555.

ppu_pkg::coord_t     precount_q;
logic [W_POST-1:0]   postcount_q;
ppu_pkg::word_addr_t base_q;
ppu_pkg::word_addr_t addr_q;
logic                active_q;
logic                setup_q;
logic                live_q;
logic                outside;
logic                beam_adv;

logic                load_req;
logic                pix_vld;
logic                pix_rdy;
logic                pix_alpha;
ppu_pkg::pix_t       pix_data;

assign outside  = (precount_q != '0) || (postcount_q == '0);
assign beam_adv = out_vld && out_rdy;

// ======================================================================
// Beam counters
// ======================================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		precount_q  <= '0;
		postcount_q <= '0;
		active_q    <= 1'b0;
		setup_q     <= 1'b0;
		live_q      <= 1'b0;
	end else begin
		setup_q <= flush;
		live_q  <= live_q || flush; // No output before the first line.
		if (flush) begin
			precount_q  <= spr_x;
			postcount_q <= W_POST'(`PPU_SPRITE_W);
			active_q    <= spr_active;
		end else if (beam_adv) begin
			if (precount_q != '0)
				precount_q <= precount_q - 1'b1;
			else if (postcount_q != '0)
				postcount_q <= postcount_q - 1'b1;
		end
	end
end

// ======================================================================
// Fetch side
// ======================================================================

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		addr_q <= '0;
	end else if (flush) begin
		addr_q <= spr_base;
	end else if (fetch.vld && fetch.rdy) begin
		addr_q <= addr_q + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (flush)
		base_q <= spr_base;
end

// Prefetch runs ahead of the beam while the sprite still owes pixels.
assign fetch.vld  = load_req && active_q && !flush && !setup_q && (postcount_q != '0);
assign fetch.addr = addr_q;

ppu_pixel_streamer streamer_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.flush        (flush),
	.mode         (mode),
	.palette_offs (palette_offs),
	.load_req     (load_req),
	.load_ack     (fetch.rdy),
	.load_data    (fetch.data),
	.pix_vld      (pix_vld),
	.pix_rdy      (pix_rdy),
	.pix_alpha    (pix_alpha),
	.pix_data     (pix_data)
);

// ======================================================================
// Output gating
// ======================================================================

assign pix_rdy     = out_rdy && !outside;
assign out_vld     = live_q && !flush && !setup_q && (outside || pix_vld || !active_q);
assign out_alpha   = en && active_q && !outside && pix_alpha;
assign out_pixdata = out_alpha ? pix_data : '0;

a_fetch_in_sprite: assert property (
	@(posedge clk) disable iff (!rst_n)
	fetch.vld |-> (ppu_pkg::word_addr_t'(fetch.addr - base_q) < SPRITE_WORDS)
) else $error("sprite fetch address %h outside base %h", fetch.addr, base_q);

endmodule

// File: rtl/ppu_sprite_compositor.sv
`timescale 1ns/1ns

module ppu_sprite_compositor (
	input  logic          s0_vld,
	output logic          s0_rdy,
	input  logic          s0_alpha,
	input  ppu_pkg::pix_t s0_pix,

	input  logic          s1_vld,
	output logic          s1_rdy,
	input  logic          s1_alpha,
	input  ppu_pkg::pix_t s1_pix,

	output logic          out_vld,
	input  logic          out_rdy,
	output logic          out_alpha,
	output ppu_pkg::pix_t out_pixdata
);

// ======================================================================
// Stream join
// ======================================================================

// Both sprites sit at the same beam position, so they move in lockstep.
assign out_vld = s0_vld && s1_vld;
assign s0_rdy  = out_rdy && s1_vld;
assign s1_rdy  = out_rdy && s0_vld;

// ======================================================================
// Priority merge
// ======================================================================

assign out_alpha   = s0_alpha || s1_alpha;
assign out_pixdata = s0_alpha ? s0_pix : s1_pix; // Sprite 0 on top.

endmodule

// File: rtl/ppu_sprite_pair.sv
`timescale 1ns/1ns

module ppu_sprite_pair (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   line_start,
	input  logic                   en,

	input  ppu_pkg::pix_mode_e     pix_mode,
	input  ppu_pkg::palette_offs_t palette_offs,

	input  ppu_pkg::coord_t        spr0_x,
	input  ppu_pkg::word_addr_t    spr0_base,
	input  logic                   spr0_active,
	input  ppu_pkg::coord_t        spr1_x,
	input  ppu_pkg::word_addr_t    spr1_base,
	input  logic                   spr1_active,

	output logic                   wb_cyc,
	output logic                   wb_stb,
	output ppu_pkg::word_addr_t    wb_adr,
	input  ppu_pkg::bus_word_t     wb_dat_i,
	input  logic                   wb_ack,

	output logic                   out_vld,
	input  logic                   out_rdy,
	output logic                   out_alpha,
	output ppu_pkg::pix_t          out_pixdata
);

ppu_fetch_if fetch0 ();
ppu_fetch_if fetch1 ();

logic          s0_vld;
logic          s0_rdy;
logic          s0_alpha;
ppu_pkg::pix_t s0_pix;
logic          s1_vld;
logic          s1_rdy;
logic          s1_alpha;
ppu_pkg::pix_t s1_pix;

ppu_sprite spr0_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.flush        (line_start),
	.en           (en),
	.spr_x        (spr0_x),
	.spr_base     (spr0_base),
	.spr_active   (spr0_active),
	.mode         (pix_mode),
	.palette_offs (palette_offs),
	.fetch        (fetch0.requester),
	.out_vld      (s0_vld),
	.out_rdy      (s0_rdy),
	.out_alpha    (s0_alpha),
	.out_pixdata  (s0_pix)
);

ppu_sprite spr1_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.flush        (line_start),
	.en           (en),
	.spr_x        (spr1_x),
	.spr_base     (spr1_base),
	.spr_active   (spr1_active),
	.mode         (pix_mode),
	.palette_offs (palette_offs),
	.fetch        (fetch1.requester),
	.out_vld      (s1_vld),
	.out_rdy      (s1_rdy),
	.out_alpha    (s1_alpha),
	.out_pixdata  (s1_pix)
);

ppu_fetch_arbiter arb_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.flush    (line_start),
	.req0     (fetch0.responder),
	.req1     (fetch1.responder),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_adr   (wb_adr),
	.wb_dat_i (wb_dat_i),
	.wb_ack   (wb_ack)
);

ppu_sprite_compositor comp_i (
	.s0_vld      (s0_vld),
	.s0_rdy      (s0_rdy),
	.s0_alpha    (s0_alpha),
	.s0_pix      (s0_pix),
	.s1_vld      (s1_vld),
	.s1_rdy      (s1_rdy),
	.s1_alpha    (s1_alpha),
	.s1_pix      (s1_pix),
	.out_vld     (out_vld),
	.out_rdy     (out_rdy),
	.out_alpha   (out_alpha),
	.out_pixdata (out_pixdata)
);

endmodule

// File: sim/tb_ppu_checks.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module tb_ppu_checks (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   line_start,
	input logic                   en,
	input ppu_pkg::pix_mode_e     pix_mode,
	input ppu_pkg::palette_offs_t palette_offs,
	input ppu_pkg::coord_t        spr0_x,
	input ppu_pkg::word_addr_t    spr0_base,
	input logic                   spr0_active,
	input ppu_pkg::coord_t        spr1_x,
	input ppu_pkg::word_addr_t    spr1_base,
	input logic                   spr1_active,
	input logic                   wb_cyc,
	input logic                   wb_stb,
	input ppu_pkg::word_addr_t    wb_adr,
	input logic                   wb_ack,
	input logic                   out_vld,
	input logic                   out_rdy,
	input logic                   out_alpha,
	input ppu_pkg::pix_t          out_pixdata
);

ppu_pkg::coord_t     x0_q;
ppu_pkg::word_addr_t base0_q;
logic                act0_q;
ppu_pkg::coord_t     x1_q;
ppu_pkg::word_addr_t base1_q;
logic                act1_q;
int                  beam_q;
int                  pix_cnt;
int                  pix_errs = 0;
int                  bus_errs = 0;
int                  seq_errs = 0;
logic                pix_acc;
logic [15:0]         view0;
logic [15:0]         view1;
logic                exp_alpha;
ppu_pkg::pix_t       exp_pix;

// Returns {alpha, colour} of one sprite at a beam position.
function automatic logic [15:0] sprite_view(input int beam, input int x,
	input ppu_pkg::word_addr_t base, input logic act, input logic on,
	input ppu_pkg::pix_mode_e mode, input ppu_pkg::palette_offs_t pal);
	int                 offs;
	ppu_pkg::bus_word_t w;
	logic [7:0]         idx;
	logic [15:0]        half;
	offs = beam - x;
	if (!on || !act || offs < 0 || offs >= `PPU_SPRITE_W)
		return 16'h0000;
	if (mode == ppu_pkg::PIX_PAL8) begin
		w   = tb_ppu_sprite_pair.mem[8'(base + offs / 4)];
		idx = w[8 * (offs % 4) +: 8];
		return (idx == 8'h00) ? 16'h0000 : {1'b1, 3'b000, pal, idx};
	end
	w    = tb_ppu_sprite_pair.mem[8'(base + offs / 2)]; // Low half first.
	half = w[16 * (offs % 2) +: 16];
	return half[15] ? half : 16'h0000;
endfunction

function automatic logic in_region(input ppu_pkg::word_addr_t adr,
	input ppu_pkg::word_addr_t base, input logic act);
	return act && (ppu_pkg::word_addr_t'(adr - base) < (`PPU_SPRITE_W / 2));
endfunction

// ======================================================================
// Reference beam model
// ======================================================================

assign pix_acc = out_vld && out_rdy;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		beam_q  <= 0;
		pix_cnt <= 0;
	end else if (line_start) begin
		beam_q  <= 0;
		x0_q    <= spr0_x;
		base0_q <= spr0_base;
		act0_q  <= spr0_active;
		x1_q    <= spr1_x;
		base1_q <= spr1_base;
		act1_q  <= spr1_active;
	end else if (pix_acc) begin
		beam_q  <= beam_q + 1;
		pix_cnt <= pix_cnt + 1;
	end
end

always_comb begin
	view0     = sprite_view(beam_q, int'(x0_q), base0_q, act0_q, en, pix_mode, palette_offs);
	view1     = sprite_view(beam_q, int'(x1_q), base1_q, act1_q, en, pix_mode, palette_offs);
	exp_alpha = view0[15] || view1[15];
	exp_pix   = view0[15] ? view0[14:0] : view1[14:0]; // Sprite 0 on top.
end

// ======================================================================
// Checks
// ======================================================================

a_alpha: assert property (@(posedge clk) disable iff (!rst_n)
	pix_acc |-> (out_alpha == exp_alpha)
) else begin
	pix_errs++;
	$error("mismatch at %0t: out_alpha at beam %0d expected %b, got %b",
		$time, $sampled(beam_q), $sampled(exp_alpha), $sampled(out_alpha));
end

a_pixdata: assert property (@(posedge clk) disable iff (!rst_n)
	(pix_acc && exp_alpha) |-> (out_pixdata == exp_pix)
) else begin
	pix_errs++;
	$error("mismatch at %0t: out_pixdata at beam %0d expected %h, got %h",
		$time, $sampled(beam_q), $sampled(exp_pix), $sampled(out_pixdata));
end

a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
else begin
	bus_errs++;
	$error("wishbone stb was high without cyc at %0t", $time);
end

a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
	(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr))
) else begin
	bus_errs++;
	$error("wishbone read dropped or its address moved before ack at %0t", $time);
end

a_adr_region: assert property (@(posedge clk) disable iff (!rst_n)
	$rose(wb_cyc) |-> (in_region(wb_adr, base0_q, act0_q) || in_region(wb_adr, base1_q, act1_q))
) else begin
	bus_errs++;
	$error("wishbone address %h lies outside both sprite regions at %0t",
		$sampled(wb_adr), $time);
end

a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (!out_vld && !wb_cyc))
else begin
	seq_errs++;
	$error("out_vld or wb_cyc was high when reset ended at %0t", $time);
end

a_start_gap: assert property (@(posedge clk) disable iff (!rst_n)
	line_start |-> !out_vld ##1 !out_vld
) else begin
	seq_errs++;
	$error("out_vld came up within two cycles of line_start at %0t", $time);
end

endmodule

// File: sim/tb_ppu_sprite_pair.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

bind ppu_sprite_pair tb_ppu_checks checks_i (.*);

module tb_ppu_sprite_pair;

localparam int NUM_LINES  = 12;
localparam int MAX_CYCLES = NUM_LINES * `PPU_LINE_W * 8;
localparam int ABORT_LINE = 8; // Next line_start lands on an open read.

// One column per scanline.
localparam int X0 [NUM_LINES]   = '{8, 40, 0, 48, 4, 32, 8, 56, 20, 24, 0, 44};
localparam int B0 [NUM_LINES]   = '{16, 24, 32, 40, 48, 52, 56, 112, 72, 128, 0, 88};
localparam int A0 [NUM_LINES]   = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 1};
localparam int X1 [NUM_LINES]   = '{16, 24, 0, 8, 12, 32, 20, 52, 30, 36, 0, 48};
localparam int B1 [NUM_LINES]   = '{64, 72, 96, 104, 80, 84, 92, 120, 136, 136, 0, 152};
localparam int A1 [NUM_LINES]   = '{1, 1, 1, 0, 1, 1, 1, 1, 1, 1, 0, 1};
localparam int MODE [NUM_LINES] = '{0, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0, 1};
localparam int PAL [NUM_LINES]  = '{0, 0, 0, 0, 9, 3, 5, 0, 0, 0, 0, 12};
localparam int EN [NUM_LINES]   = '{1, 1, 1, 1, 1, 1, 0, 1, 1, 1, 1, 1};

logic                   clk;
logic                   rst_n;
logic                   line_start;
logic                   en;
ppu_pkg::pix_mode_e     pix_mode;
ppu_pkg::palette_offs_t palette_offs;
ppu_pkg::coord_t        spr0_x;
ppu_pkg::word_addr_t    spr0_base;
logic                   spr0_active;
ppu_pkg::coord_t        spr1_x;
ppu_pkg::word_addr_t    spr1_base;
logic                   spr1_active;
logic                   wb_cyc;
logic                   wb_stb;
ppu_pkg::word_addr_t    wb_adr;
ppu_pkg::bus_word_t     wb_dat_i;
logic                   wb_ack;
logic                   out_vld;
logic                   out_rdy;
logic                   out_alpha;
ppu_pkg::pix_t          out_pixdata;

ppu_pkg::bus_word_t     mem [0:255];
int                     seed = 32'h8ae4_5d67;
int                     cycle_cnt;

ppu_sprite_pair ppu_sprite_pair_i (.*);

function automatic ppu_pkg::bus_word_t fill_word(input logic [7:0] a);
	ppu_pkg::bus_word_t w;
	w = ({24'h0, a} * 32'h9e37_79b1) ^ 32'h6d2b_79f5;
	if (a[1])
		w[8 * a[3:2] +: 8] = 8'h00; // Transparent PAL8 index.
	return w;
endfunction

function automatic logic draw_rdy();
	return ($random(seed) & 3) != 0; // Stall about one cycle in four.
endfunction

task automatic report_counts();
	$display("summary: %0d pixels checked, %0d pixel errors, %0d bus errors, %0d timing errors",
		ppu_sprite_pair_i.checks_i.pix_cnt, ppu_sprite_pair_i.checks_i.pix_errs,
		ppu_sprite_pair_i.checks_i.bus_errs, ppu_sprite_pair_i.checks_i.seq_errs);
endtask

// Runs one scanline, ending after 64 accepted pixels or on an open read.
task automatic run_line(input int i);
	int   count;
	logic done;
	@(posedge clk);
	#5;
	en           = (EN[i] != 0);
	pix_mode     = ppu_pkg::pix_mode_e'(MODE[i][0]);
	palette_offs = ppu_pkg::palette_offs_t'(PAL[i]);
	spr0_x       = ppu_pkg::coord_t'(X0[i]);
	spr0_base    = ppu_pkg::word_addr_t'(B0[i]);
	spr0_active  = (A0[i] != 0);
	spr1_x       = ppu_pkg::coord_t'(X1[i]);
	spr1_base    = ppu_pkg::word_addr_t'(B1[i]);
	spr1_active  = (A1[i] != 0);
	line_start   = 1'b1;
	@(posedge clk);
	#5;
	line_start = 1'b0;
	count      = 0;
	done       = 1'b0;
	while (!done) begin
		out_rdy = draw_rdy();
		@(negedge clk);
		if (out_vld && out_rdy)
			count++;
		if (count == `PPU_LINE_W)
			done = 1'b1;
		else if (i == ABORT_LINE && count >= X0[i] && wb_cyc && !wb_ack)
			done = 1'b1;
		else begin
			@(posedge clk);
			#5;
		end
	end
endtask

// ======================================================================
// Clock, memory and timeout
// ======================================================================

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

initial begin
	for (int a = 0; a < 256; a++)
		mem[a] = fill_word(8'(a));
end

// Single beat reads, ack after 0 to 3 wait cycles.
initial begin
	int   wait_cnt;
	logic busy;
	wait_cnt = 0;
	busy     = 1'b0;
	forever begin
		@(posedge clk);
		#5;
		if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = $random(seed) & 3;
			end
			if (wait_cnt == 0) begin
				wb_ack   = 1'b1;
				wb_dat_i = mem[wb_adr[7:0]];
				busy     = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
	end
end

initial begin
	cycle_cnt = 0;
	while (cycle_cnt < MAX_CYCLES) begin
		@(posedge clk);
		cycle_cnt++;
	end
	$display("run did not finish within %0d cycles", MAX_CYCLES);
	report_counts();
	$display("tests failed");
	$finish;
end

// ======================================================================
// Stimulus
// ======================================================================

initial begin
	int errs;
	rst_n        = 1'b0;
	line_start   = 1'b0;
	en           = 1'b0;
	pix_mode     = ppu_pkg::PIX_ARGB1555;
	palette_offs = '0;
	spr0_x       = '0;
	spr0_base    = '0;
	spr0_active  = 1'b0;
	spr1_x       = '0;
	spr1_base    = '0;
	spr1_active  = 1'b0;
	wb_dat_i     = '0;
	wb_ack       = 1'b0;
	out_rdy      = 1'b0;
	repeat (10) @(posedge clk);
	#5;
	rst_n = 1'b1;
	repeat (2) @(posedge clk);
	for (int i = 0; i < NUM_LINES; i++)
		run_line(i);
	repeat (4) @(posedge clk); // Let the last checks fire.
	errs = ppu_sprite_pair_i.checks_i.pix_errs + ppu_sprite_pair_i.checks_i.bus_errs
		+ ppu_sprite_pair_i.checks_i.seq_errs;
	report_counts();
	if (errs == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule
